// ==== logic/isa_pkg.sv ====
package isa_pkg;

  typedef logic [31:0] instr_t;

  typedef enum logic [1:0] {
    TYPE_NOP   = 2'd0,
    TYPE_ARITH = 2'd1,
    TYPE_MEM   = 2'd2,  // Not supported, decodes as bubble
    TYPE_AUDIO = 2'd3   // Not supported, decodes as bubble
  } instr_type_e;

  typedef enum logic [2:0] {
    OP_ADD       = 3'd1,
    OP_INC       = 3'd3,
    OP_MOVE_LOW  = 3'd5,
    OP_MOVE_HIGH = 3'd6,
    OP_MOVE      = 3'd7
  } arith_op_e;

  // Instruction word layout
  localparam int IMM_FLAG_BIT = 31;
  localparam int TYPE_MSB     = 30;
  localparam int TYPE_LSB     = 29;
  localparam int OP_MSB       = 28;
  localparam int OP_LSB       = 26;
  localparam int R1_MSB       = 21;
  localparam int R1_LSB       = 19;
  localparam int R2_MSB       = 18;
  localparam int R2_LSB       = 16;
  localparam int IMM_LSB      = 0;
  localparam int IMM_W        = 16;

  function automatic instr_type_e instr_type(instr_t instr);
    return instr_type_e'(instr[TYPE_MSB:TYPE_LSB]);
  endfunction

  function automatic arith_op_e instr_op(instr_t instr);
    return arith_op_e'(instr[OP_MSB:OP_LSB]);
  endfunction

  function automatic logic [R1_MSB-R1_LSB:0] instr_r1(instr_t instr);
    return instr[R1_MSB:R1_LSB];
  endfunction

  function automatic logic [R2_MSB-R2_LSB:0] instr_r2(instr_t instr);
    return instr[R2_MSB:R2_LSB];
  endfunction

  function automatic logic [IMM_W-1:0] instr_imm(instr_t instr);
    return instr[IMM_LSB +: IMM_W];
  endfunction

  // Arithmetic class with a defined operation code
  function automatic logic instr_valid(instr_t instr);
    if (instr_type(instr) != TYPE_ARITH) return 1'b0;
    case (instr_op(instr))
      OP_ADD, OP_INC, OP_MOVE_LOW, OP_MOVE_HIGH, OP_MOVE: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

// ==== logic/core_pkg.sv ====
package core_pkg;

  localparam int XLEN     = 32;
  localparam int HALF_W   = XLEN / 2;
  localparam int NUM_REGS = 8;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [2:0]      reg_idx_t;

  // Bit 0 low half, bit 1 high half
  typedef logic [1:0] half_we_t;

  localparam half_we_t WE_NONE = 2'b00;
  localparam half_we_t WE_LOW  = 2'b01;
  localparam half_we_t WE_HIGH = 2'b10;
  localparam half_we_t WE_FULL = 2'b11;

  // Result source resolved in EX
  typedef enum logic {
    WB_ALU     = 1'b0,
    WB_OPERAND = 1'b1
  } wb_sel_e;

endpackage

// ==== logic/program_memory.sv ====
module program_memory #(
  parameter int PROG_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          prog_we,
  input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
  input  isa_pkg::instr_t               prog_data,
  input  logic [$clog2(PROG_DEPTH)-1:0] pc,
  output isa_pkg::instr_t               instr
);
  import isa_pkg::*;

  // All zero words are no-ops until loaded
  instr_t mem [PROG_DEPTH] = '{default: '0};

  // Load port, only used while the core is held in reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  assign instr = mem[pc];  // Asynchronous read

endmodule

// ==== logic/fetch_stage.sv ====
module fetch_stage #(
  parameter int PROG_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          stall,
  input  isa_pkg::instr_t               instr,
  output logic [$clog2(PROG_DEPTH)-1:0] pc,
  output isa_pkg::instr_t               if_id_instr
);

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      pc          <= '0;
      if_id_instr <= '0;
    end else if (!stall) begin
      pc          <= pc + 1'b1;  // Wraps at PROG_DEPTH
      if_id_instr <= instr;
    end
    // Stalled: PC and IF/ID both hold
  end

endmodule

// ==== logic/hazard_unit.sv ====
module hazard_unit (
  input  isa_pkg::instr_t id_instr,
  input  isa_pkg::instr_t ex_instr,
  input  isa_pkg::instr_t mem_instr,
  input  isa_pkg::instr_t wb_instr,
  output logic            stall
);
  import isa_pkg::*;

  logic id_reads_r2;
  logic r1_hit;
  logic r2_hit;

  // Older instruction will still write register idx
  function automatic logic dest_match(instr_t older, logic [R1_MSB-R1_LSB:0] idx);
    return instr_valid(older) && (instr_r1(older) == idx);
  endfunction

  // Only register form ADD and MOVE source r2
  assign id_reads_r2 = (instr_op(id_instr) == OP_MOVE) ||
                       (instr_op(id_instr) == OP_ADD && !id_instr[IMM_FLAG_BIT]);

  assign r1_hit = dest_match(ex_instr, instr_r1(id_instr)) ||
                  dest_match(mem_instr, instr_r1(id_instr)) ||
                  dest_match(wb_instr, instr_r1(id_instr));

  assign r2_hit = dest_match(ex_instr, instr_r2(id_instr)) ||
                  dest_match(mem_instr, instr_r2(id_instr)) ||
                  dest_match(wb_instr, instr_r2(id_instr));

  // Hold decode until the producer has left WB
  assign stall = instr_valid(id_instr) && (r1_hit || (id_reads_r2 && r2_hit));

endmodule

// ==== logic/decode_stage.sv ====
module decode_stage (
  input  logic                clk,
  input  logic                resetn,
  input  logic                stall,
  input  isa_pkg::instr_t     if_id_instr,
  output core_pkg::reg_idx_t  rs1,
  output core_pkg::reg_idx_t  rs2,
  input  core_pkg::word_t     rs1_value,
  input  core_pkg::word_t     rs2_value,
  output isa_pkg::instr_t     ex_instr,
  output isa_pkg::arith_op_e  alu_op,
  output core_pkg::word_t     operand1,
  output core_pkg::word_t     operand2,
  output core_pkg::half_we_t  wr_en,
  output core_pkg::wb_sel_e   wb_sel
);
  import isa_pkg::*;
  import core_pkg::*;

  arith_op_e        op;
  logic [IMM_W-1:0] imm;
  logic             take_bubble;
  word_t            op2_next;
  half_we_t         we_next;
  wb_sel_e          sel_next;

  assign op  = instr_op(if_id_instr);
  assign imm = instr_imm(if_id_instr);
  assign rs1 = instr_r1(if_id_instr);
  assign rs2 = instr_r2(if_id_instr);

  // NOP, memory, audio and unknown ops all go down as bubbles
  assign take_bubble = stall || !instr_valid(if_id_instr);

  always_comb begin
    op2_next = rs2_value;
    we_next  = WE_FULL;
    sel_next = WB_ALU;
    case (op)
      OP_ADD: begin
        if (if_id_instr[IMM_FLAG_BIT]) begin
          op2_next = {{(XLEN-IMM_W){1'b0}}, imm};  // Zero extended
        end
      end
      OP_INC: ;
      OP_MOVE: sel_next = WB_OPERAND;
      OP_MOVE_LOW: begin
        op2_next = {{(XLEN-IMM_W){1'b0}}, imm};
        we_next  = WE_LOW;
        sel_next = WB_OPERAND;
      end
      OP_MOVE_HIGH: begin
        op2_next = {imm, {(XLEN-IMM_W){1'b0}}};
        we_next  = WE_HIGH;
        sel_next = WB_OPERAND;
      end
      default: we_next = WE_NONE;
    endcase
  end

  // ID/EX register
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ex_instr <= '0;
      alu_op   <= arith_op_e'(3'b000);
      operand1 <= '0;
      operand2 <= '0;
      wr_en    <= WE_NONE;
      wb_sel   <= WB_ALU;
    end else if (take_bubble) begin
      ex_instr <= '0;
      alu_op   <= arith_op_e'(3'b000);
      operand1 <= '0;
      operand2 <= '0;
      wr_en    <= WE_NONE;
      wb_sel   <= WB_ALU;
    end else begin
      ex_instr <= if_id_instr;
      alu_op   <= op;
      operand1 <= rs1_value;
      operand2 <= op2_next;
      wr_en    <= we_next;
      wb_sel   <= sel_next;
    end
  end

endmodule

// ==== logic/execute_stage.sv ====
module execute_stage (
  input  logic               clk,
  input  logic               resetn,
  input  isa_pkg::instr_t    ex_instr,
  input  isa_pkg::arith_op_e alu_op,
  input  core_pkg::word_t    operand1,
  input  core_pkg::word_t    operand2,
  input  core_pkg::half_we_t wr_en,
  input  core_pkg::wb_sel_e  wb_sel,
  output isa_pkg::instr_t    mem_instr,
  output core_pkg::word_t    mem_result,
  output core_pkg::half_we_t mem_wr_en
);
  import isa_pkg::*;
  import core_pkg::*;

  word_t alu_result;

  // Two operation ALU, sums wrap at 32 bits
  always_comb begin
    case (alu_op)
      OP_ADD:  alu_result = operand1 + operand2;
      OP_INC:  alu_result = operand1 + word_t'(1);
      default: alu_result = '0;  // Moves bypass the ALU
    endcase
  end

  // EX/MEM register, result source picked here
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      mem_instr  <= '0;
      mem_result <= '0;
      mem_wr_en  <= WE_NONE;
    end else begin
      mem_instr  <= ex_instr;
      mem_result <= (wb_sel == WB_OPERAND) ? operand2 : alu_result;
      mem_wr_en  <= wr_en;
    end
  end

endmodule

// ==== logic/writeback_stage.sv ====
module writeback_stage (
  input  logic               clk,
  input  logic               resetn,
  input  isa_pkg::instr_t    mem_instr,
  input  core_pkg::word_t    mem_result,
  input  core_pkg::half_we_t mem_wr_en,
  output isa_pkg::instr_t    wb_instr,
  output core_pkg::half_we_t rf_we,
  output core_pkg::reg_idx_t rf_waddr,
  output core_pkg::word_t    rf_wdata,
  output logic               retire
);
  import isa_pkg::*;
  import core_pkg::*;

  word_t    wb_result;
  half_we_t wb_wr_en;

  // MEM/WB register, MEM stage itself has no work left
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wb_instr  <= '0;
      wb_result <= '0;
      wb_wr_en  <= WE_NONE;
    end else begin
      wb_instr  <= mem_instr;
      wb_result <= mem_result;
      wb_wr_en  <= mem_wr_en;
    end
  end

  // Register file commits at the edge closing this cycle
  assign rf_we    = wb_wr_en;
  assign rf_waddr = instr_r1(wb_instr);  // Destination is always r1
  assign rf_wdata = wb_result;

  assign retire = (wb_instr != '0);  // Bubbles are all zero

endmodule

// ==== logic/reg_file.sv ====
module reg_file (
  input  logic               clk,
  input  logic               resetn,
  input  core_pkg::reg_idx_t rs1,
  input  core_pkg::reg_idx_t rs2,
  input  core_pkg::reg_idx_t dbg_sel,
  output core_pkg::word_t    rs1_value,
  output core_pkg::word_t    rs2_value,
  output core_pkg::word_t    dbg_value,
  input  core_pkg::half_we_t we,
  input  core_pkg::reg_idx_t waddr,
  input  core_pkg::word_t    wdata
);
  import core_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Each half has its own enable
      if (we[0]) begin
        regs[waddr][HALF_W-1:0] <= wdata[HALF_W-1:0];
      end
      if (we[1]) begin
        regs[waddr][XLEN-1:HALF_W] <= wdata[XLEN-1:HALF_W];
      end
    end
  end

  // Read ports, no bypass from the write port
  assign rs1_value = regs[rs1];
  assign rs2_value = regs[rs2];
  assign dbg_value = regs[dbg_sel];

endmodule

// ==== logic/cpu_top.sv ====
module cpu_top #(
  parameter int PROG_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          prog_we,
  input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
  input  isa_pkg::instr_t               prog_data,
  input  core_pkg::reg_idx_t            dbg_sel,
  output core_pkg::word_t               dbg_value,
  output logic                          stall,
  output logic                          retire
);
  import isa_pkg::*;
  import core_pkg::*;

  localparam int PC_W = $clog2(PROG_DEPTH);

  logic [PC_W-1:0] pc;
  instr_t          instr;
  instr_t          if_id_instr;

  // Decode and register file read
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  word_t     rs1_value;
  word_t     rs2_value;

  // ID/EX
  instr_t    ex_instr;
  arith_op_e alu_op;
  word_t     operand1;
  word_t     operand2;
  half_we_t  wr_en;
  wb_sel_e   wb_sel;

  // EX/MEM
  instr_t    mem_instr;
  word_t     mem_result;
  half_we_t  mem_wr_en;

  // MEM/WB and register write
  instr_t    wb_instr;
  half_we_t  rf_we;
  reg_idx_t  rf_waddr;
  word_t     rf_wdata;

  program_memory #(.PROG_DEPTH(PROG_DEPTH)) program_memory_inst (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .instr     (instr)
  );

  fetch_stage #(.PROG_DEPTH(PROG_DEPTH)) fetch_stage_inst (
    .clk         (clk),
    .resetn      (resetn),
    .stall       (stall),
    .instr       (instr),
    .pc          (pc),
    .if_id_instr (if_id_instr)
  );

  hazard_unit hazard_unit_inst (
    .id_instr  (if_id_instr),
    .ex_instr  (ex_instr),
    .mem_instr (mem_instr),
    .wb_instr  (wb_instr),
    .stall     (stall)
  );

  decode_stage decode_stage_inst (
    .clk         (clk),
    .resetn      (resetn),
    .stall       (stall),
    .if_id_instr (if_id_instr),
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .ex_instr    (ex_instr),
    .alu_op      (alu_op),
    .operand1    (operand1),
    .operand2    (operand2),
    .wr_en       (wr_en),
    .wb_sel      (wb_sel)
  );

  execute_stage execute_stage_inst (
    .clk        (clk),
    .resetn     (resetn),
    .ex_instr   (ex_instr),
    .alu_op     (alu_op),
    .operand1   (operand1),
    .operand2   (operand2),
    .wr_en      (wr_en),
    .wb_sel     (wb_sel),
    .mem_instr  (mem_instr),
    .mem_result (mem_result),
    .mem_wr_en  (mem_wr_en)
  );

  writeback_stage writeback_stage_inst (
    .clk        (clk),
    .resetn     (resetn),
    .mem_instr  (mem_instr),
    .mem_result (mem_result),
    .mem_wr_en  (mem_wr_en),
    .wb_instr   (wb_instr),
    .rf_we      (rf_we),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .retire     (retire)
  );

  reg_file reg_file_inst (
    .clk       (clk),
    .resetn    (resetn),
    .rs1       (rs1),
    .rs2       (rs2),
    .dbg_sel   (dbg_sel),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .dbg_value (dbg_value),
    .we        (rf_we),
    .waddr     (rf_waddr),
    .wdata     (rf_wdata)
  );

endmodule

// ==== tb/cpu_tb_assert.sv ====
module cpu_tb_assert #(
  parameter int PC_W = 6
) (
  input logic            clk,
  input logic            resetn,
  input logic            stall,
  input logic            retire,
  input logic [PC_W-1:0] pc,
  input logic [31:0]     ex_instr
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;

  // Nothing moves while held in reset
  quiet_in_reset: assert property (@(posedge clk) !resetn |-> (!stall && !retire))
    else begin
      $error("stall or retire high during reset");
      fail_cnt++;
    end

  pc_holds_on_stall: assert property (@(posedge clk) disable iff (!resetn)
    stall |=> $stable(pc))
    else begin
      $error("PC moved while stalled");
      fail_cnt++;
    end

  bubble_after_stall: assert property (@(posedge clk) disable iff (!resetn)
    stall |=> (ex_instr == 32'h0))
    else begin
      $error("ID/EX not a bubble after a stall");
      fail_cnt++;
    end

endmodule

bind cpu_top cpu_tb_assert #(.PC_W(PC_W)) cpu_tb_assert_inst (
  .clk      (clk),
  .resetn   (resetn),
  .stall    (stall),
  .retire   (retire),
  .pc       (pc),
  .ex_instr (ex_instr)
);

// ==== tb/cpu_tb.sv ====
module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import isa_pkg::*;
  import core_pkg::*;

  localparam int PROG_DEPTH     = 64;
  localparam int PC_W           = $clog2(PROG_DEPTH);
  localparam int NUM_TESTS      = 5;
  localparam int RUN_CYCLES     = 4 * PROG_DEPTH;
  localparam int TIMEOUT_CYCLES = 4 * PROG_DEPTH * NUM_TESTS + 100;

  logic            clk;
  logic            resetn;
  logic            prog_we;
  logic [PC_W-1:0] prog_addr;
  instr_t          prog_data;
  reg_idx_t        dbg_sel;
  word_t           dbg_value;
  logic            stall;
  logic            retire;

  instr_t      prog [PROG_DEPTH];
  logic [31:0] rng_state;
  int          retire_cnt;
  logic        stall_seen;
  int          cycle_cnt;
  int          error_cnt;
  int          tests_passed;
  int          tests_failed;

  cpu_top #(.PROG_DEPTH(PROG_DEPTH)) cpu_top_inst (
    .clk       (clk),
    .resetn    (resetn),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .dbg_sel   (dbg_sel),
    .dbg_value (dbg_value),
    .stall     (stall),
    .retire    (retire)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Retire and stall watchers cleared by each reset
  always @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      retire_cnt <= 0;
      stall_seen <= 1'b0;
    end else begin
      if (retire) retire_cnt <= retire_cnt + 1;
      if (stall) stall_seen <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Word layout is imm flag, type, op, unused, r1, r2, imm
  function automatic instr_t encode(input logic f, input logic [1:0] typ, input logic [2:0] op,
                                    input logic [2:0] r1, input logic [2:0] r2,
                                    input logic [15:0] imm);
    return {f, typ, op, 4'b0000, r1, r2, imm};
  endfunction

  // Sequential model returning the number of instructions that retire
  function automatic int ref_run(input instr_t p [PROG_DEPTH], output word_t r [8]);
    int          cnt;
    logic [31:0] w;
    logic [2:0]  d;
    logic [2:0]  s;
    logic [15:0] imm;
    cnt = 0;
    for (int i = 0; i < 8; i++) r[i] = '0;
    for (int k = 0; k < PROG_DEPTH; k++) begin
      w   = p[k];
      d   = w[21:19];
      s   = w[18:16];
      imm = w[15:0];
      if (w[30:29] == 2'd1) begin
        case (w[28:26])
          3'd1: begin
            r[d] = r[d] + (w[31] ? {16'h0000, imm} : r[s]);
            cnt++;
          end
          3'd3: begin
            r[d] = r[d] + 32'd1;
            cnt++;
          end
          3'd5: begin
            r[d][15:0] = imm;
            cnt++;
          end
          3'd6: begin
            r[d][31:16] = imm;
            cnt++;
          end
          3'd7: begin
            r[d] = r[s];
            cnt++;
          end
          default: ;  // Undefined op is a bubble
        endcase
      end
    end
    return cnt;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic clear_prog();
    for (int i = 0; i < PROG_DEPTH; i++) prog[i] = '0;
  endtask

  task automatic run_test(input string name, input logic need_stall);
    word_t exp_regs [8];
    int    expected;
    int    waited;
    int    errs_at_start;
    errs_at_start = error_cnt;
    expected = ref_run(prog, exp_regs);
    resetn = 1'b0;
    // Whole memory rewritten so old programs leave nothing behind
    for (int i = 0; i < PROG_DEPTH; i++) begin
      prog_we   = 1'b1;
      prog_addr = PC_W'(i);
      prog_data = prog[i];
      next_cycle();
    end
    prog_we = 1'b0;
    repeat (3) next_cycle();
    resetn = 1'b1;
    waited = 0;
    while (retire_cnt < expected && waited < RUN_CYCLES) begin
      next_cycle();
      waited++;
    end
    if (retire_cnt < expected) begin
      $display("%s: only %0d of %0d instructions retired", name, retire_cnt, expected);
      error_cnt++;
    end
    repeat (4) next_cycle();  // Catch any extra retire
    if (retire_cnt != expected) begin
      $display("MISMATCH %s retire count: expected %0d actual %0d", name, expected, retire_cnt);
      error_cnt++;
    end
    for (int i = 0; i < 8; i++) begin
      dbg_sel = reg_idx_t'(i);
      next_cycle();  // Debug read settled a full cycle later
      if (dbg_value !== exp_regs[i]) begin
        $display("MISMATCH %s r%0d: expected %08h actual %08h", name, i, exp_regs[i],
                 dbg_value);
        error_cnt++;
      end
    end
    if (need_stall && !stall_seen) begin
      $display("%s: stall never went high on a dependent chain", name);
      error_cnt++;
    end
    if (error_cnt == errs_at_start) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: failed", name);
      tests_failed++;
    end
  endtask

  initial begin
    logic [31:0] r;
    int          assert_fails;
    resetn       = 1'b0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    dbg_sel      = '0;
    cycle_cnt    = 0;
    error_cnt    = 0;
    tests_passed = 0;
    tests_failed = 0;
    rng_state    = 32'h4ca6_35b8;
    next_cycle();

    // Each register gets one half written
    clear_prog();
    for (int i = 0; i < 8; i++) begin
      rng_state = xorshift(rng_state);
      prog[i] = encode(1'b0, 2'd1, (i % 2) ? 3'd6 : 3'd5, 3'(i), 3'd0, rng_state[15:0]);
    end
    run_test("independent", 1'b0);

    clear_prog();
    rng_state = xorshift(rng_state);
    prog[0] = encode(1'b0, 2'd1, 3'd6, 3'd1, 3'd0, 16'hffff);
    prog[1] = encode(1'b0, 2'd1, 3'd5, 3'd1, 3'd0, 16'hfff0);
    prog[2] = encode(1'b0, 2'd1, 3'd5, 3'd2, 3'd0, rng_state[15:0]);
    prog[3] = encode(1'b0, 2'd1, 3'd6, 3'd3, 3'd0, rng_state[31:16]);
    prog[4] = encode(1'b1, 2'd1, 3'd1, 3'd1, 3'd0, 16'h0020);  // Wraps past 32 bits
    prog[5] = encode(1'b0, 2'd1, 3'd3, 3'd4, 3'd0, 16'h0000);
    prog[6] = encode(1'b0, 2'd1, 3'd1, 3'd3, 3'd2, 16'h0000);
    prog[7] = encode(1'b0, 2'd1, 3'd3, 3'd1, 3'd0, 16'h0000);
    prog[8] = encode(1'b0, 2'd1, 3'd1, 3'd5, 3'd1, 16'h0000);
    prog[9] = encode(1'b1, 2'd1, 3'd1, 3'd6, 3'd0, rng_state[23:8]);
    run_test("arithmetic", 1'b0);

    clear_prog();
    rng_state = xorshift(rng_state);
    prog[0] = encode(1'b0, 2'd1, 3'd5, 3'd2, 3'd0, rng_state[15:0]);
    prog[1] = encode(1'b0, 2'd1, 3'd6, 3'd2, 3'd0, rng_state[31:16]);
    prog[2] = encode(1'b0, 2'd1, 3'd6, 3'd5, 3'd0, 16'hbeef);
    prog[3] = encode(1'b0, 2'd1, 3'd5, 3'd5, 3'd0, 16'h1357);
    prog[4] = encode(1'b0, 2'd1, 3'd5, 3'd7, 3'd0, rng_state[23:8]);
    prog[5] = encode(1'b0, 2'd1, 3'd6, 3'd7, 3'd0, 16'h8001);
    prog[6] = encode(1'b0, 2'd1, 3'd5, 3'd7, 3'd0, 16'h0042);
    run_test("half_writes", 1'b0);

    // Every instruction depends on the one before
    clear_prog();
    prog[0] = encode(1'b0, 2'd1, 3'd5, 3'd1, 3'd0, 16'h1234);
    prog[1] = encode(1'b0, 2'd1, 3'd1, 3'd1, 3'd1, 16'h0000);
    prog[2] = encode(1'b0, 2'd1, 3'd7, 3'd2, 3'd1, 16'h0000);
    prog[3] = encode(1'b0, 2'd1, 3'd1, 3'd2, 3'd1, 16'h0000);
    prog[4] = encode(1'b0, 2'd1, 3'd3, 3'd2, 3'd0, 16'h0000);
    prog[5] = encode(1'b0, 2'd1, 3'd7, 3'd3, 3'd2, 16'h0000);
    prog[6] = encode(1'b1, 2'd1, 3'd1, 3'd3, 3'd0, 16'h00ff);
    run_test("dependent_chain", 1'b1);

    // Arithmetic words with any op code mixed with raw random words
    clear_prog();
    for (int i = 0; i < 10; i++) begin
      rng_state = xorshift(rng_state);
      r = rng_state;
      if (r[0]) prog[i] = encode(r[31], 2'd1, r[28:26], r[21:19], r[18:16], r[15:0]);
      else prog[i] = r;
    end
    run_test("bubbles", 1'b0);

    assert_fails = cpu_top_inst.cpu_tb_assert_inst.fail_cnt;
    $display("%0d tests: %0d passed, %0d failed, %0d errors, %0d assertion failures",
             NUM_TESTS, tests_passed, tests_failed, error_cnt, assert_fails);
    if (error_cnt == 0 && assert_fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
logic/isa_pkg.sv
logic/core_pkg.sv
logic/program_memory.sv
logic/fetch_stage.sv
logic/hazard_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/reg_file.sv
logic/cpu_top.sv
tb/cpu_tb_assert.sv
tb/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Output goes to the terminal, status comes from the search
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf $(BUILD_DIR)
